//--- common/lcd_pkg.sv
package lcd_pkg;

	// bus word and configuration widths
	localparam int lcd_bus_w = 10;	// rs, rw, data
	localparam int data_w = 8;
	localparam int bus_rs = 9;
	localparam int bus_rw = 8;
	localparam int cfg_w = 7;

	// display_cfg bit positions
	localparam int cfg_lines = 6;	// two-line mode
	localparam int cfg_font = 5;
	localparam int cfg_disp = 4;	// display on
	localparam int cfg_cursor = 3;
	localparam int cfg_blink = 2;
	localparam int cfg_inc = 1;	// address increment
	localparam int cfg_shift = 0;

	// panel geometry
	localparam int cols = 16;
	localparam int rows = 2;
	localparam int addr_w = 5;
	localparam logic [7:0] line0_base = 8'h80;	// set ddram addr 0x00
	localparam logic [7:0] line1_base = 8'hC0;	// set ddram addr 0x40
	localparam logic [7:0] space_char = 8'h20;

	// instruction codes
	localparam logic [7:0] wake_cmd = 8'h30;
	localparam logic [3:0] fs_op = 4'b0011;	// function set, 8-bit bus
	localparam logic [4:0] onoff_op = 5'b00001;
	localparam logic [7:0] clear_cmd = 8'h01;
	localparam logic [5:0] entry_op = 6'b000001;

	// timing in microseconds
	localparam int powerup_us = 500;
	localparam int pulse_us = 10;
	localparam int cmd_wait_us = 50;
	localparam int clear_wait_us = 200;
	localparam int entry_wait_us = 100;
	localparam int xfer_us = 50;
	localparam int e_lead_us = 1;	// e low before the pulse
	localparam int e_high_us = 13;

endpackage

//--- dv/lcd_display_assert.sv
`timescale 1ns/1ps

module lcd_ctrl_assert (
	input logic       clk,
	input logic       rst_n,
	input logic       lcd_enable,
	input logic       busy,
	input logic       e,
	input logic       rs,
	input logic       rw,
	input logic [7:0] lcd_data
);

	// panel latches on the falling edge of e, so the bus must not move under it
	property bus_stable_p;
		@(posedge clk) disable iff (!rst_n)
		$past(e) |-> $stable({rs, rw, lcd_data});
	endproperty

	property e_idle_p;
		@(posedge clk) disable iff (!rst_n)
		!busy |-> !e;
	endproperty

	property accept_busy_p;
		@(posedge clk) disable iff (!rst_n)
		(lcd_enable && !busy) |=> busy;	// taken only in ready
	endproperty

	a_bus_stable: assert property (bus_stable_p)
		else $error("rs, rw or lcd_data changed while e was high");
	a_e_idle: assert property (e_idle_p)
		else $error("e high while controller not busy");
	a_accept_busy: assert property (accept_busy_p)
		else $error("busy not raised after an accepted lcd_enable");

endmodule

bind lcd_ctrl lcd_ctrl_assert u_lcd_ctrl_assert (
	.clk        (clk),
	.rst_n      (rst_n),
	.lcd_enable (lcd_enable),
	.busy       (busy),
	.e          (e),
	.rs         (rs),
	.rw         (rw),
	.lcd_data   (lcd_data)
);

//--- dv/lcd_display_tb.sv
`timescale 1ns/1ps

module lcd_display_tb;

	localparam int clk_per_us = 2;
	localparam int clk_ns = 4;
	localparam int n_refresh = 5;	// tests 2, 3, 4 and two in test 5
	localparam int seq_len = 2 * (lcd_pkg::cols + 1);
	localparam int init_us = 5 * lcd_pkg::pulse_us + 3 * lcd_pkg::cmd_wait_us +
		lcd_pkg::clear_wait_us + lcd_pkg::entry_wait_us;
	localparam int run_us = lcd_pkg::powerup_us + init_us +
		n_refresh * seq_len * lcd_pkg::xfer_us;
	localparam int limit_cyc = run_us * clk_per_us * 5 / 4 + 2000;	// writer overhead + gaps

	logic                       clk;
	logic                       rst_n;
	logic [lcd_pkg::cfg_w-1:0]  display_cfg;
	logic                       buf_wr;
	logic [lcd_pkg::addr_w-1:0] buf_addr;
	logic [7:0]                 buf_char;
	logic                       refresh;
	logic                       ready;
	logic                       e;
	logic                       rs;
	logic                       rw;
	logic [7:0]                 lcd_data;

	logic [9:0] obs_q [$];	// words seen on the panel bus
	logic [9:0] exp_q [$];
	logic [7:0] model_buf [32];
	int         cmp_cnt = 0;

	lcd_display_top #(
		.clk_per_us (clk_per_us)
	) u_lcd_display_top (
		.clk         (clk),
		.rst_n       (rst_n),
		.display_cfg (display_cfg),
		.buf_wr      (buf_wr),
		.buf_addr    (buf_addr),
		.buf_char    (buf_char),
		.refresh     (refresh),
		.ready       (ready),
		.e           (e),
		.rs          (rs),
		.rw          (rw),
		.lcd_data    (lcd_data)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_ns / 2) clk = ~clk;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1, "simulation stopped on first failure");
	endtask

	// HD44780 instruction encoding with idx as init step 0..4 or refresh slot 0..33
	function automatic logic [9:0] ref_word(input bit init_seq, input int idx,
		input logic [6:0] cfg);
		logic [7:0] cmd;
		if (init_seq) begin
			case (idx)
				0: cmd = 8'h30;	// wake in 8-bit mode
				1: cmd = 8'h30 | {4'b0, cfg[6], cfg[5], 2'b0};
				2: cmd = 8'h08 | {5'b0, cfg[4:2]};
				3: cmd = 8'h01;
				default: cmd = 8'h04 | {6'b0, cfg[1:0]};
			endcase
			return {2'b00, cmd};
		end
		if (idx == 0) begin
			return {2'b00, lcd_pkg::line0_base};
		end
		if (idx == lcd_pkg::cols + 1) begin
			return {2'b00, lcd_pkg::line1_base};
		end
		if (idx <= lcd_pkg::cols) begin
			return {2'b10, model_buf[idx - 1]};
		end
		return {2'b10, model_buf[idx - 2]};
	endfunction

	task automatic queue_init();
		for (int i = 0; i < 5; i++) begin
			exp_q.push_back(ref_word(1'b1, i, display_cfg));
		end
	endtask

	task automatic queue_refresh();
		for (int i = 0; i < seq_len; i++) begin
			exp_q.push_back(ref_word(1'b0, i, display_cfg));
		end
	endtask

	task automatic pulse_refresh();
		@(negedge clk);
		refresh = 1'b1;
		@(negedge clk);
		refresh = 1'b0;
	endtask

	task automatic wait_ready();
		while (!ready) begin
			@(negedge clk);
		end
	endtask

	// one full refresh checked for exactly one sequence of words
	task automatic run_refresh();
		int start;
		start = cmp_cnt;
		queue_refresh();
		pulse_refresh();
		assert (!ready) else fail_run("refresh pulse was not taken by the writer");
		wait_ready();
		assert (cmp_cnt - start == seq_len && exp_q.size() == 0)
			else fail_run($sformatf("ERR @%0t: refresh gave %0d words, expected %0d",
				$time, cmp_cnt - start, seq_len));
	endtask

	// e rising edge seen at negedge when the bus has settled
	initial begin : bus_monitor
		logic e_q;
		e_q = 1'b0;
		forever begin
			@(negedge clk);
			if (e && !e_q) begin
				obs_q.push_back({rs, rw, lcd_data});
			end
			e_q = e;
		end
	end

	initial begin : compare_words
		logic [9:0] got;
		logic [9:0] want;
		forever begin
			@(posedge clk);
			while (obs_q.size() != 0) begin
				got = obs_q.pop_front();
				assert (exp_q.size() != 0)
					else fail_run($sformatf("ERR @%0t: unexpected bus word %h", $time, got));
				assert (got[8] == 1'b0)
					else fail_run($sformatf("ERR @%0t: rw high on word %0d", $time, cmp_cnt));
				want = exp_q.pop_front();
				assert (got == want)
					else fail_run($sformatf("ERR @%0t: word %0d got %h expected %h",
						$time, cmp_cnt, got, want));
				cmp_cnt++;
			end
		end
	end

	initial begin : watchdog
		#(limit_cyc * clk_ns);
		fail_run($sformatf("timeout: run did not finish within %0d clock cycles", limit_cyc));
	end

	initial begin : stimulus
		int start;
		rst_n = 1'b0;
		display_cfg = '0;
		buf_wr = 1'b0;
		buf_addr = '0;
		buf_char = '0;
		refresh = 1'b0;
		void'($urandom(32'hd2db_583f));
		display_cfg = 7'($urandom);
		for (int i = 0; i < 32; i++) begin
			model_buf[i] = 8'h20;	// blank screen after reset
		end
		queue_init();
		repeat (2) @(negedge clk);
		rst_n = 1'b1;

		// init words before ready, with a refresh pulse during power-up
		pulse_refresh();
		wait_ready();
		assert (cmp_cnt == 5 && exp_q.size() == 0)
			else fail_run($sformatf("ERR @%0t: ready rose after %0d init words", $time, cmp_cnt));

		// refresh of the reset contents
		run_refresh();

		// random text at every address
		for (int a = 0; a < 32; a++) begin
			@(negedge clk);
			buf_wr = 1'b1;
			buf_addr = 5'(a);
			buf_char = 8'($urandom_range(8'h7e, 8'h21));
			model_buf[a] = buf_char;
		end
		@(negedge clk);
		buf_wr = 1'b0;
		run_refresh();

		// a second pulse mid-refresh must not add transfers
		start = cmp_cnt;
		queue_refresh();
		pulse_refresh();
		while (cmp_cnt < start + 3) begin
			@(negedge clk);
		end
		pulse_refresh();
		wait_ready();
		repeat (3 * lcd_pkg::xfer_us * clk_per_us) @(negedge clk);	// quiet window
		assert (cmp_cnt - start == seq_len && obs_q.size() == 0 && exp_q.size() == 0)
			else fail_run($sformatf("ERR @%0t: %0d words after ignored pulse, expected %0d",
				$time, cmp_cnt - start, seq_len));

		// two refreshes back to back
		run_refresh();
		run_refresh();

		$display("Done: no errors");
		$finish;
	end

endmodule

//--- lcd_ctrl/lcd_ctrl.sv
`timescale 1ns/1ps

module lcd_ctrl #(
	parameter int clk_per_us = 20
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [lcd_pkg::cfg_w-1:0]     display_cfg,
	input  logic                          lcd_enable,
	input  logic [lcd_pkg::lcd_bus_w-1:0] lcd_word,
	output logic                          busy,
	output logic                          e,
	output logic                          rs,
	output logic                          rw,
	output logic [lcd_pkg::data_w-1:0]    lcd_data
);

	localparam int powerup_cyc = lcd_pkg::powerup_us * clk_per_us;
	localparam int pulse_cyc = lcd_pkg::pulse_us * clk_per_us;
	localparam int xfer_cyc = lcd_pkg::xfer_us * clk_per_us;
	localparam int lead_cyc = lcd_pkg::e_lead_us * clk_per_us;
	localparam int high_cyc = lcd_pkg::e_high_us * clk_per_us;
	localparam int cnt_w = $clog2(powerup_cyc + 1);	// power-up is the longest span
	localparam int init_len = 5;	// wake word plus four config commands

	typedef enum logic [1:0] {
		st_powerup,
		st_init,
		st_ready,
		st_xfer
	} state_t;

	state_t           state;
	logic [cnt_w-1:0] cnt;
	logic [cnt_w-1:0] cnt_nxt;
	logic [2:0]       step;

	// init command for each step with config bits merged into the opcode
	function automatic logic [7:0] init_cmd(
		input logic [2:0]               idx,
		input logic [lcd_pkg::cfg_w-1:0] cfg
	);
		logic [7:0] cmd;
		case (idx)
			3'd0: cmd = lcd_pkg::wake_cmd;
			3'd1: cmd = {lcd_pkg::fs_op, cfg[lcd_pkg::cfg_lines], cfg[lcd_pkg::cfg_font], 2'b00};
			3'd2: cmd = {lcd_pkg::onoff_op, cfg[lcd_pkg::cfg_disp], cfg[lcd_pkg::cfg_cursor],
				cfg[lcd_pkg::cfg_blink]};
			3'd3: cmd = lcd_pkg::clear_cmd;
			default: cmd = {lcd_pkg::entry_op, cfg[lcd_pkg::cfg_inc], cfg[lcd_pkg::cfg_shift]};
		endcase
		return cmd;
	endfunction

	// last count of an init step is the pulse plus that command's execution time
	function automatic logic [cnt_w-1:0] step_last(input logic [2:0] idx);
		int wait_us;
		case (idx)
			3'd3: wait_us = lcd_pkg::clear_wait_us;
			3'd4: wait_us = lcd_pkg::entry_wait_us;
			default: wait_us = lcd_pkg::cmd_wait_us;
		endcase
		return cnt_w'(pulse_cyc + wait_us * clk_per_us - 1);
	endfunction

	assign cnt_nxt = cnt + 1'b1;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_powerup;
			cnt <= '0;
			step <= '0;
			busy <= 1'b1;
			e <= 1'b0;
			rs <= 1'b0;
			rw <= 1'b0;
			lcd_data <= '0;
		end else begin
			case (state)
				st_powerup: begin
					if (cnt == cnt_w'(powerup_cyc - 1)) begin
						state <= st_init;
						cnt <= '0;
						step <= '0;
						e <= 1'b1;	// first pulse starts right away
						lcd_data <= init_cmd(3'd0, display_cfg);
					end else begin
						cnt <= cnt_nxt;
					end
				end
				st_init: begin
					if (cnt == step_last(step)) begin
						cnt <= '0;
						if (step == 3'(init_len - 1)) begin
							state <= st_ready;
							busy <= 1'b0;
							e <= 1'b0;
							lcd_data <= '0;
						end else begin
							step <= step + 3'd1;
							e <= 1'b1;
							lcd_data <= init_cmd(step + 3'd1, display_cfg);
						end
					end else begin
						cnt <= cnt_nxt;
						e <= (cnt_nxt < cnt_w'(pulse_cyc));	// data held through the wait
					end
				end
				st_ready: begin
					if (lcd_enable) begin
						state <= st_xfer;
						busy <= 1'b1;
						cnt <= '0;
						rs <= lcd_word[lcd_pkg::bus_rs];
						rw <= lcd_word[lcd_pkg::bus_rw];
						lcd_data <= lcd_word[lcd_pkg::data_w-1:0];
					end
				end
				st_xfer: begin
					if (cnt == cnt_w'(xfer_cyc - 1)) begin
						state <= st_ready;
						busy <= 1'b0;
						cnt <= '0;
						e <= 1'b0;
						rs <= 1'b0;
						rw <= 1'b0;
						lcd_data <= '0;
					end else begin
						cnt <= cnt_nxt;
						// 1 us setup, 13 us high, low for the remainder
						e <= (cnt_nxt >= cnt_w'(lead_cyc)) &&
							(cnt_nxt < cnt_w'(lead_cyc + high_cyc));
					end
				end
				default: state <= st_powerup;
			endcase
		end
	end

endmodule

//--- rtl/lcd_display_top.sv
`timescale 1ns/1ps

module lcd_display_top #(
	parameter int clk_per_us = 20
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [lcd_pkg::cfg_w-1:0]  display_cfg,
	input  logic                       buf_wr,
	input  logic [lcd_pkg::addr_w-1:0] buf_addr,
	input  logic [7:0]                 buf_char,
	input  logic                       refresh,
	output logic                       ready,
	output logic                       e,
	output logic                       rs,
	output logic                       rw,
	output logic [lcd_pkg::data_w-1:0] lcd_data
);

	logic [lcd_pkg::addr_w-1:0]    rd_addr;
	logic [7:0]                    rd_char;
	logic                          lcd_enable;
	logic [lcd_pkg::lcd_bus_w-1:0] lcd_word;
	logic                          busy;

	text_buffer u_text_buffer (
		.clk     (clk),
		.wr      (buf_wr),
		.wr_addr (buf_addr),
		.wr_char (buf_char),
		.rd_addr (rd_addr),
		.rd_char (rd_char)
	);

	screen_writer u_screen_writer (
		.clk        (clk),
		.rst_n      (rst_n),
		.refresh    (refresh),
		.busy       (busy),
		.rd_addr    (rd_addr),
		.rd_char    (rd_char),
		.lcd_enable (lcd_enable),
		.lcd_word   (lcd_word),
		.ready      (ready)
	);

	lcd_ctrl #(
		.clk_per_us (clk_per_us)
	) u_lcd_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.display_cfg (display_cfg),
		.lcd_enable  (lcd_enable),
		.lcd_word    (lcd_word),
		.busy        (busy),
		.e           (e),
		.rs          (rs),
		.rw          (rw),
		.lcd_data    (lcd_data)
	);

endmodule

//--- rtl/screen_writer.sv
`timescale 1ns/1ps

module screen_writer (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          refresh,
	input  logic                          busy,
	output logic [lcd_pkg::addr_w-1:0]    rd_addr,
	input  logic [7:0]                    rd_char,
	output logic                          lcd_enable,
	output logic [lcd_pkg::lcd_bus_w-1:0] lcd_word,
	output logic                          ready
);

	localparam int line1_step = lcd_pkg::cols + 1;	// second address command
	localparam int last_step = 2 * (lcd_pkg::cols + 1) - 1;
	localparam int step_w = $clog2(last_step + 1);

	typedef enum logic [2:0] {
		st_idle,
		st_fetch,
		st_issue,
		st_wait_hi,
		st_wait_lo
	} state_t;

	state_t            state;
	logic [step_w-1:0] step;
	logic [step_w-1:0] char_idx;
	logic              addr_step;
	logic              init_done;

	assign addr_step = (step == '0) || (step == step_w'(line1_step));

	// skip one address slot per line
	assign char_idx = (step < step_w'(line1_step)) ? step - step_w'(1) : step - step_w'(2);
	assign rd_addr = char_idx[lcd_pkg::addr_w-1:0];

	always_comb begin
		if (addr_step) begin
			lcd_word = {1'b0, 1'b0, (step == '0) ? lcd_pkg::line0_base : lcd_pkg::line1_base};
		end else begin
			lcd_word = {1'b1, 1'b0, rd_char};	// data write
		end
	end

	assign lcd_enable = (state == st_issue) && !busy;
	assign ready = init_done && (state == st_idle);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_idle;
			step <= '0;
			init_done <= 1'b0;
		end else begin
			if (!busy) begin
				init_done <= 1'b1;	// controller finished its init
			end
			case (state)
				st_idle: begin
					if (refresh && init_done) begin
						step <= '0;
						state <= st_fetch;
					end
				end
				st_fetch: state <= st_issue;	// rd_char valid next cycle
				st_issue: begin
					if (!busy) begin
						state <= st_wait_hi;
					end
				end
				st_wait_hi: begin
					if (busy) begin
						state <= st_wait_lo;
					end
				end
				st_wait_lo: begin
					if (!busy) begin
						if (step == step_w'(last_step)) begin
							state <= st_idle;
						end else begin
							step <= step + 1'b1;
							state <= st_fetch;
						end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

//--- rtl/text_buffer.sv
`timescale 1ns/1ps

module text_buffer (
	input  logic                       clk,
	input  logic                       wr,
	input  logic [lcd_pkg::addr_w-1:0] wr_addr,
	input  logic [7:0]                 wr_char,
	input  logic [lcd_pkg::addr_w-1:0] rd_addr,
	output logic [7:0]                 rd_char
);

	localparam int depth = lcd_pkg::rows * lcd_pkg::cols;

	logic [7:0] mem [depth];	// line 0 at 0..15, line 1 at 16..31

	// powers up as a blank screen
	initial begin
		for (int i = 0; i < depth; i++) begin
			mem[i] = lcd_pkg::space_char;
		end
	end

	always_ff @(posedge clk) begin
		if (wr) begin
			mem[wr_addr] <= wr_char;	// host writes always land
		end
	end

	// one cycle of read latency
	always_ff @(posedge clk) begin
		rd_char <= mem[rd_addr];
	end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the LCD display testbench with Verilator.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module lcd_display_tb -f tb.f -o lcd_display_sim
if [ $? -ne 0 ]; then
	echo "FAIL: verilator build failed"
	exit 1
fi

./obj_dir/lcd_display_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "FAIL: simulation exited with status $status"
	exit 1
fi

if grep -qx "Done: no errors" "$log"; then
	echo "PASS"
	exit 0
fi
echo "FAIL: pass message not found in $log"
exit 1

//--- tb.f
common/lcd_pkg.sv
lcd_ctrl/lcd_ctrl.sv
rtl/text_buffer.sv
rtl/screen_writer.sv
rtl/lcd_display_top.sv
dv/lcd_display_assert.sv
dv/lcd_display_tb.sv
